/* Bender.yml */
package:
  name: icache

sources:
  - files:
      - icache_pkg.sv
      - icache_tag_array.sv
      - icache_data_array.sv
      - icache_replace.sv
      - icache_refill.sv
      - icache_ctrl.sv
      - icache_top.sv
  - target: test
    files:
      - tb_icache_asserts.sv
      - tb_icache.sv

/* icache_ctrl.sv */
`default_nettype none

module icache_ctrl #(
    parameter int NUM_SETS    = 8,
    parameter int NUM_WAYS    = 4,
    parameter int BLOCK_WORDS = 4
) (
    input  logic                                                Clk,
    input  logic                                                reset,
    input  logic                                                read_enable,
    input  icache_pkg::addr_t                                   read_address,
    input  logic                                                mispredict,
    input  logic                                                hit,
    input  logic [$clog2(NUM_WAYS)-1:0]                         hit_way,
    input  logic [$clog2(NUM_WAYS)-1:0]                         victim_way,
    input  logic                                                block_done,
    input  icache_pkg::word_t [BLOCK_WORDS-1:0]                 fill_block,
    input  icache_pkg::word_t                                   data_read_data,
    output logic [$clog2(NUM_SETS)-1:0]                         lookup_set,
    output logic [31-$clog2(NUM_SETS)-$clog2(BLOCK_WORDS)-2:0]  lookup_tag,
    output logic                                                data_read_strobe,
    output logic [$clog2(NUM_SETS)-1:0]                         data_read_set,
    output logic [$clog2(NUM_WAYS)-1:0]                         data_read_way,
    output logic [$clog2(BLOCK_WORDS)-1:0]                      data_read_word,
    output logic                                                fill_write,
    output logic [$clog2(NUM_SETS)-1:0]                         fill_set,
    output logic [$clog2(NUM_WAYS)-1:0]                         fill_way,
    output logic [31-$clog2(NUM_SETS)-$clog2(BLOCK_WORDS)-2:0]  fill_tag,
    output logic                                                refill_start,
    output logic                                                refill_cancel,
    output icache_pkg::word_t                                   instruction,
    output logic                                                ready,
    output logic                                                busy,
    output icache_pkg::addr_t                                   mem_read_address,
    output logic                                                mem_read_request
);

    import icache_pkg::*;

    localparam int OFF_W  = $clog2(BLOCK_WORDS) + 2;
    localparam int SET_W  = $clog2(NUM_SETS);
    localparam int WORD_W = $clog2(BLOCK_WORDS);
    localparam int TAG_W  = 32 - SET_W - OFF_W;

    typedef logic [SET_W-1:0]  set_t;
    typedef logic [WORD_W-1:0] word_sel_t;
    typedef logic [TAG_W-1:0]  tag_t;

    ctrl_state_e state;
    logic        accept;
    logic        hit_ready;
    set_t        miss_set;
    tag_t        miss_tag;
    word_sel_t   miss_word;
    logic [$clog2(NUM_WAYS)-1:0] miss_way;

    // Address split of the incoming fetch
    assign lookup_set = read_address[OFF_W +: SET_W];
    assign lookup_tag = read_address[31 -: TAG_W];

    // Strobes while busy or with a mispredict are dropped
    assign accept = read_enable && !mispredict && (state == LOOKUP);

    assign data_read_strobe = accept && hit;
    assign data_read_set    = lookup_set;
    assign data_read_way    = hit_way;
    assign data_read_word   = read_address[2 +: WORD_W];

    assign refill_start  = accept && !hit;
    assign refill_cancel = (state == REFILL) && mispredict;

    assign fill_write = (state == FILL);
    assign fill_set   = miss_set;
    assign fill_way   = miss_way;
    assign fill_tag   = miss_tag;

    // Request address is rebuilt from the missed tag and set
    assign mem_read_address = {miss_tag, miss_set, {OFF_W{1'b0}}};

    always_ff @(posedge Clk) begin
        if (reset) begin
            state            <= LOOKUP;
            busy             <= 1'b0;
            mem_read_request <= 1'b0;
            hit_ready        <= 1'b0;
        end else begin
            hit_ready <= accept && hit;
            case (state)
                LOOKUP: begin
                    if (refill_start) begin
                        state            <= REFILL;
                        busy             <= 1'b1;
                        mem_read_request <= 1'b1;
                    end
                end
                REFILL: begin
                    // Cancel takes priority over a finishing burst
                    if (mispredict) begin
                        state            <= LOOKUP;
                        busy             <= 1'b0;
                        mem_read_request <= 1'b0;
                    end else if (block_done) begin
                        state            <= FILL;
                        mem_read_request <= 1'b0;
                    end
                end
                FILL: begin
                    state <= LOOKUP;
                    busy  <= 1'b0;
                end
                default: begin
                    state <= LOOKUP;
                end
            endcase
        end
    end

    // Miss context, kept until the fill
    always_ff @(posedge Clk) begin
        if (refill_start) begin
            miss_set  <= lookup_set;
            miss_tag  <= lookup_tag;
            miss_word <= data_read_word;
            miss_way  <= victim_way;
        end
    end

    // Critical word bypasses the array while it is being written
    assign ready       = hit_ready || (state == FILL);
    assign instruction = (state == FILL) ? fill_block[miss_word] : data_read_data;

endmodule

`default_nettype wire

/* icache_data_array.sv */
`default_nettype none

module icache_data_array #(
    parameter int NUM_SETS    = 8,
    parameter int NUM_WAYS    = 4,
    parameter int BLOCK_WORDS = 4
) (
    input  logic                                  Clk,
    input  logic                                  read_strobe,
    input  logic [$clog2(NUM_SETS)-1:0]           read_set,
    input  logic [$clog2(NUM_WAYS)-1:0]           read_way,
    input  logic [$clog2(BLOCK_WORDS)-1:0]        read_word,
    input  logic                                  fill_write,
    input  logic [$clog2(NUM_SETS)-1:0]           fill_set,
    input  logic [$clog2(NUM_WAYS)-1:0]           fill_way,
    input  icache_pkg::word_t [BLOCK_WORDS-1:0]   fill_block,
    output icache_pkg::word_t                     read_data
);

    import icache_pkg::*;

    word_t words [NUM_SETS][NUM_WAYS][BLOCK_WORDS];

    // Whole block lands in one cycle
    always_ff @(posedge Clk) begin
        if (fill_write) begin
            for (int k = 0; k < BLOCK_WORDS; k++) begin
                words[fill_set][fill_way][k] <= fill_block[k];
            end
        end
    end

    // Output holds its value between strobes
    always_ff @(posedge Clk) begin
        if (read_strobe) begin
            read_data <= words[read_set][read_way][read_word];
        end
    end

endmodule

`default_nettype wire

/* icache_golden.txt */
# M <address> <word>                       memory image word, hex
# T <name>                                 starts a test
# F <address> <mode> <instruction> <hit>   mode 0 plain, 1 mispredict in refill,
#                                          2 extra strobe while busy; hit 1, miss 0
M 10000010 00000513
M 10000014 00100593
M 1000001c 00b50633
M 10000024 fff60613
M 10000028 00c586b3
M 20000030 02000713
M 2000003c 0007a783
M 200000b0 00f707b3
M 200000b4 00178793
M 20000134 40e787b3
M 20000138 00279813
M 200001b8 01080833
M 200001bc 00082883
M 20000230 0118a023
M 20000234 fe0718e3
M 30000048 00008067
M 40000050 00a12023
M 40000058 00412083
M 40000064 ff010113
M 4000007c 00112623
M 50000000 0080006f
M 50000004 00000013
T cold_miss
F 10000014 0 00100593 0
F 10000028 0 00c586b3 0
T hit_after_fill
F 10000010 0 00000513 1
F 1000001c 0 00b50633 1
F 10000024 0 fff60613 1
T replacement
F 20000030 0 02000713 0
F 200000b4 0 00178793 0
F 20000138 0 00279813 0
F 200001bc 0 00082883 0
F 20000230 0 0118a023 0
F 20000134 0 40e787b3 1
F 200001b8 0 01080833 1
F 20000234 0 fe0718e3 1
F 200000b0 0 00f707b3 1
F 2000003c 0 0007a783 0
T mispredict_cancel
F 30000040 1 00000000 0
F 30000048 0 00008067 0
T memory_gaps
F 40000058 0 00412083 0
F 40000064 0 ff010113 0
F 4000007c 0 00112623 0
F 40000050 0 00a12023 1
T ignored_strobe
F 50000000 2 0080006f 0
F 50000004 0 00000013 1

/* icache_pkg.sv */
`default_nettype none

package icache_pkg;

    // Byte address as seen by the fetch stage and the memory side
    typedef logic [31:0] addr_t;

    // One instruction, also the width of a memory data beat
    typedef logic [31:0] word_t;

    // Controller states
    // LOOKUP serves hits and detects misses
    // REFILL waits for the memory burst or a mispredict
    // FILL writes the block and returns the requested word
    typedef enum logic [1:0] {
        LOOKUP,
        REFILL,
        FILL
    } ctrl_state_e;

endpackage

`default_nettype wire

/* icache_refill.sv */
`default_nettype none

module icache_refill #(
    parameter int BLOCK_WORDS = 4
) (
    input  logic                                  Clk,
    input  logic                                  reset,
    input  logic                                  start,
    input  logic                                  cancel,
    input  logic                                  mem_data_ready,
    input  icache_pkg::word_t                     mem_data_in,
    output logic                                  block_done,
    output icache_pkg::word_t [BLOCK_WORDS-1:0]   fill_block
);

    import icache_pkg::*;

    localparam int CNT_W = $clog2(BLOCK_WORDS);

    typedef logic [CNT_W-1:0] count_t;

    localparam count_t LAST_WORD = count_t'(BLOCK_WORDS - 1);

    logic   active;
    count_t count;
    logic   take_word;

    // Words are only accepted while a burst is open
    assign take_word = active && mem_data_ready && !cancel;

    // Strobe of the final beat, the buffer holds it from the next cycle on
    assign block_done = take_word && (count == LAST_WORD);

    always_ff @(posedge Clk) begin
        if (reset) begin
            active <= 1'b0;
            count  <= '0;
        end else if (cancel) begin
            active <= 1'b0;
            count  <= '0;
        end else if (start) begin
            active <= 1'b1;
            count  <= '0;
        end else if (take_word) begin
            count <= count + count_t'(1);
            if (count == LAST_WORD) begin
                active <= 1'b0;
            end
        end
    end

    // Memory returns words in address order, so the count is the offset
    always_ff @(posedge Clk) begin
        if (take_word) begin
            fill_block[count] <= mem_data_in;
        end
    end

endmodule

`default_nettype wire

/* icache_replace.sv */
`default_nettype none

module icache_replace #(
    parameter int NUM_SETS = 8,
    parameter int NUM_WAYS = 4
) (
    input  logic                          Clk,
    input  logic                          reset,
    input  logic [$clog2(NUM_SETS)-1:0]   set_index,
    input  logic [NUM_WAYS-1:0]           set_valid_mask,
    input  logic                          advance,
    input  logic [$clog2(NUM_SETS)-1:0]   advance_set,
    input  logic [$clog2(NUM_WAYS)-1:0]   advance_way,
    output logic [$clog2(NUM_WAYS)-1:0]   victim_way
);

    localparam int WAY_W = $clog2(NUM_WAYS);

    typedef logic [WAY_W-1:0] way_t;

    way_t pointer [NUM_SETS];

    // Round-robin pointer per set, moved just past the way filled last
    always_ff @(posedge Clk) begin
        if (reset) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                pointer[s] <= '0;
            end
        end else if (advance) begin
            if (advance_way == way_t'(NUM_WAYS - 1)) begin
                pointer[advance_set] <= '0;
            end else begin
                pointer[advance_set] <= advance_way + way_t'(1);
            end
        end
    end

    // Lowest empty way wins, scanning downward leaves the lowest one
    always_comb begin
        victim_way = pointer[set_index];
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (!set_valid_mask[w]) begin
                victim_way = way_t'(w);
            end
        end
    end

endmodule

`default_nettype wire

/* icache_tag_array.sv */
`default_nettype none

module icache_tag_array #(
    parameter int NUM_SETS    = 8,
    parameter int NUM_WAYS    = 4,
    parameter int BLOCK_WORDS = 4
) (
    input  logic                                                Clk,
    input  logic                                                reset,
    input  logic [$clog2(NUM_SETS)-1:0]                         lookup_set,
    input  logic [31-$clog2(NUM_SETS)-$clog2(BLOCK_WORDS)-2:0]  lookup_tag,
    input  logic                                                fill_write,
    input  logic [$clog2(NUM_SETS)-1:0]                         fill_set,
    input  logic [$clog2(NUM_WAYS)-1:0]                         fill_way,
    input  logic [31-$clog2(NUM_SETS)-$clog2(BLOCK_WORDS)-2:0]  fill_tag,
    output logic                                                hit,
    output logic [$clog2(NUM_WAYS)-1:0]                         hit_way,
    output logic [NUM_WAYS-1:0]                                 set_valid_mask
);

    localparam int SET_W = $clog2(NUM_SETS);
    localparam int WAY_W = $clog2(NUM_WAYS);
    localparam int TAG_W = 32 - SET_W - $clog2(BLOCK_WORDS) - 2;

    typedef logic [TAG_W-1:0] tag_t;
    typedef logic [WAY_W-1:0] way_t;

    tag_t                tags  [NUM_SETS][NUM_WAYS];
    logic [NUM_WAYS-1:0] valid [NUM_SETS];

    // Valid bits are the only state that must start known
    always_ff @(posedge Clk) begin
        if (reset) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid[s] <= '0;
            end
        end else if (fill_write) begin
            valid[fill_set][fill_way] <= 1'b1;
        end
    end

    always_ff @(posedge Clk) begin
        if (fill_write) begin
            tags[fill_set][fill_way] <= fill_tag;
        end
    end

    // Compare every way of the set in parallel
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (valid[lookup_set][w] && (tags[lookup_set][w] == lookup_tag)) begin
                hit     = 1'b1;
                hit_way = way_t'(w);
            end
        end
    end

    // Victim choice needs to know which ways are still empty
    assign set_valid_mask = valid[lookup_set];

endmodule

`default_nettype wire

/* icache_top.sv */
`default_nettype none

module icache_top #(
    parameter int NUM_SETS    = 8,
    parameter int NUM_WAYS    = 4,
    parameter int BLOCK_WORDS = 4
) (
    input  logic              Clk,
    input  logic              reset,
    input  logic              read_enable,
    input  icache_pkg::addr_t read_address,
    input  logic              mispredict,
    input  icache_pkg::word_t mem_data_in,
    input  logic              mem_data_ready,
    output icache_pkg::word_t instruction,
    output logic              ready,
    output logic              busy,
    output icache_pkg::addr_t mem_read_address,
    output logic              mem_read_request
);

    import icache_pkg::*;

    localparam int SET_W  = $clog2(NUM_SETS);
    localparam int WAY_W  = $clog2(NUM_WAYS);
    localparam int WORD_W = $clog2(BLOCK_WORDS);
    localparam int TAG_W  = 32 - SET_W - WORD_W - 2;

    // Lookup path
    logic [SET_W-1:0]  lookup_set;
    logic [TAG_W-1:0]  lookup_tag;
    logic              hit;
    logic [WAY_W-1:0]  hit_way;
    logic [NUM_WAYS-1:0] set_valid_mask;
    logic [WAY_W-1:0]  victim_way;

    // Data read path
    logic              data_read_strobe;
    logic [SET_W-1:0]  data_read_set;
    logic [WAY_W-1:0]  data_read_way;
    logic [WORD_W-1:0] data_read_word;
    word_t             data_read_data;

    // Fill path
    logic              fill_write;
    logic [SET_W-1:0]  fill_set;
    logic [WAY_W-1:0]  fill_way;
    logic [TAG_W-1:0]  fill_tag;
    word_t [BLOCK_WORDS-1:0] fill_block;
    logic              refill_start;
    logic              refill_cancel;
    logic              block_done;

    icache_ctrl #(
        .NUM_SETS   (NUM_SETS),
        .NUM_WAYS   (NUM_WAYS),
        .BLOCK_WORDS(BLOCK_WORDS)
    ) ctrl0 (
        .Clk             (Clk),
        .reset           (reset),
        .read_enable     (read_enable),
        .read_address    (read_address),
        .mispredict      (mispredict),
        .hit             (hit),
        .hit_way         (hit_way),
        .victim_way      (victim_way),
        .block_done      (block_done),
        .fill_block      (fill_block),
        .data_read_data  (data_read_data),
        .lookup_set      (lookup_set),
        .lookup_tag      (lookup_tag),
        .data_read_strobe(data_read_strobe),
        .data_read_set   (data_read_set),
        .data_read_way   (data_read_way),
        .data_read_word  (data_read_word),
        .fill_write      (fill_write),
        .fill_set        (fill_set),
        .fill_way        (fill_way),
        .fill_tag        (fill_tag),
        .refill_start    (refill_start),
        .refill_cancel   (refill_cancel),
        .instruction     (instruction),
        .ready           (ready),
        .busy            (busy),
        .mem_read_address(mem_read_address),
        .mem_read_request(mem_read_request)
    );

    icache_tag_array #(
        .NUM_SETS   (NUM_SETS),
        .NUM_WAYS   (NUM_WAYS),
        .BLOCK_WORDS(BLOCK_WORDS)
    ) tags0 (
        .Clk           (Clk),
        .reset         (reset),
        .lookup_set    (lookup_set),
        .lookup_tag    (lookup_tag),
        .fill_write    (fill_write),
        .fill_set      (fill_set),
        .fill_way      (fill_way),
        .fill_tag      (fill_tag),
        .hit           (hit),
        .hit_way       (hit_way),
        .set_valid_mask(set_valid_mask)
    );

    icache_data_array #(
        .NUM_SETS   (NUM_SETS),
        .NUM_WAYS   (NUM_WAYS),
        .BLOCK_WORDS(BLOCK_WORDS)
    ) data0 (
        .Clk        (Clk),
        .read_strobe(data_read_strobe),
        .read_set   (data_read_set),
        .read_way   (data_read_way),
        .read_word  (data_read_word),
        .fill_write (fill_write),
        .fill_set   (fill_set),
        .fill_way   (fill_way),
        .fill_block (fill_block),
        .read_data  (data_read_data)
    );

    // Pointer moves on the same pulse that writes the arrays
    icache_replace #(
        .NUM_SETS(NUM_SETS),
        .NUM_WAYS(NUM_WAYS)
    ) replace0 (
        .Clk           (Clk),
        .reset         (reset),
        .set_index     (lookup_set),
        .set_valid_mask(set_valid_mask),
        .advance       (fill_write),
        .advance_set   (fill_set),
        .advance_way   (fill_way),
        .victim_way    (victim_way)
    );

    icache_refill #(
        .BLOCK_WORDS(BLOCK_WORDS)
    ) refill0 (
        .Clk           (Clk),
        .reset         (reset),
        .start         (refill_start),
        .cancel        (refill_cancel),
        .mem_data_ready(mem_data_ready),
        .mem_data_in   (mem_data_in),
        .block_done    (block_done),
        .fill_block    (fill_block)
    );

endmodule

`default_nettype wire

/* tb.f */
icache_pkg.sv
icache_tag_array.sv
icache_data_array.sv
icache_replace.sv
icache_refill.sv
icache_ctrl.sv
icache_top.sv
tb_icache_asserts.sv
tb_icache.sv

/* tb_icache.sv */
`default_nettype none

module tb_icache;

    timeunit 1ns;
    timeprecision 1ps;

    import icache_pkg::*;

    localparam int NUM_SETS      = 8;
    localparam int NUM_WAYS      = 4;
    localparam int BLOCK_WORDS   = 4;
    localparam int BLOCK_BYTES   = BLOCK_WORDS * 4;
    localparam int READY_TIMEOUT = 100;
    localparam int IDLE_TIMEOUT  = 100;

    logic  Clk;
    logic  reset;
    logic  read_enable;
    addr_t read_address;
    logic  mispredict;
    word_t mem_data_in;
    logic  mem_data_ready;
    word_t instruction;
    logic  ready;
    logic  busy;
    addr_t mem_read_address;
    logic  mem_read_request;

    word_t       mem_image [addr_t];
    logic [31:0] lcg_state;

    int    ready_count     = 0;
    int    request_count   = 0;
    addr_t request_address = '0;
    logic  request_seen    = 1'b0;

    int    errors       = 0;
    int    fetch_count  = 0;
    int    tests_run    = 0;
    int    tests_failed = 0;
    int    test_errors  = 0;
    int    test_fetches = 0;
    logic  test_open    = 1'b0;
    string test_name    = "";
    logic  aborted      = 1'b0;

    icache_top #(
        .NUM_SETS   (NUM_SETS),
        .NUM_WAYS   (NUM_WAYS),
        .BLOCK_WORDS(BLOCK_WORDS)
    ) dut0 (
        .Clk             (Clk),
        .reset           (reset),
        .read_enable     (read_enable),
        .read_address    (read_address),
        .mispredict      (mispredict),
        .mem_data_in     (mem_data_in),
        .mem_data_ready  (mem_data_ready),
        .instruction     (instruction),
        .ready           (ready),
        .busy            (busy),
        .mem_read_address(mem_read_address),
        .mem_read_request(mem_read_request)
    );

    always #20 Clk = ~Clk;

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic word_t memory_word(input addr_t addr);
        if (mem_image.exists(addr)) begin
            return mem_image[addr];
        end
        // Unlisted words still differ for every address
        return addr ^ {addr[15:0], addr[31:16]} ^ 32'h6b8e_1d37;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic finish_test();
        if (test_open) begin
            tests_run++;
            if (test_errors == 0) begin
                $display("test %s ok, %0d fetches", test_name, test_fetches);
            end else begin
                $display("test %s has %0d errors in %0d fetches", test_name, test_errors,
                         test_fetches);
                tests_failed++;
            end
        end
        test_open = 1'b0;
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        @(negedge Clk);
        while (busy && waited < IDLE_TIMEOUT) begin
            @(negedge Clk);
            waited++;
        end
        if (busy) begin
            $display("Timed out waiting for the cache to drop busy");
            aborted = 1'b1;
        end
    endtask

    // One fetch from strobe to the end of its response
    task automatic run_fetch(input addr_t addr, input int mode, input word_t exp_word,
                             input logic exp_hit);
        int   ready_before;
        int   request_before;
        int   waited;
        logic saw_hit;
        wait_idle();
        if (aborted) begin
            return;
        end
        fetch_count++;
        test_fetches++;
        ready_before   = ready_count;
        request_before = request_count;
        read_enable    = 1'b1;
        read_address   = addr;
        @(negedge Clk);
        read_enable = 1'b0;
        saw_hit     = ready;
        check_value("hit in the cycle after the strobe", saw_hit, exp_hit);
        if (saw_hit) begin
            check_value("hit instruction", instruction, exp_word);
        end else begin
            if (mode == 2) begin
                // Strobe to another block while the refill is running
                check_value("busy during refill", busy, 1'b1);
                read_enable  = 1'b1;
                read_address = addr ^ 32'h0000_1000;
                @(negedge Clk);
                read_enable  = 1'b0;
                read_address = addr;
            end
            if (mode == 1) begin
                @(negedge Clk);
                mispredict = 1'b1;
                @(negedge Clk);
                mispredict = 1'b0;
                check_value("request after mispredict", mem_read_request, 1'b0);
                check_value("busy after mispredict", busy, 1'b0);
            end else begin
                waited = 0;
                while (!ready && waited < READY_TIMEOUT) begin
                    @(negedge Clk);
                    waited++;
                end
                if (!ready) begin
                    $display("Timed out waiting for ready on the fetch of %h", addr);
                    aborted = 1'b1;
                    return;
                end
                check_value("refill instruction", instruction, exp_word);
            end
        end
        // Room for a stray ready or request to show up
        repeat (3) @(negedge Clk);
        check_value("ready pulses", ready_count - ready_before, (mode == 1) ? 0 : 1);
        check_value("memory requests", request_count - request_before, exp_hit ? 0 : 1);
        if (!exp_hit) begin
            check_value("request address", request_address, addr & ~addr_t'(BLOCK_BYTES - 1));
        end
    endtask

    always @(negedge Clk) begin
        if (!reset) begin
            if (ready) begin
                ready_count++;
            end
            if (mem_read_request && !request_seen) begin
                request_count++;
                request_address = mem_read_address;
            end
        end
        request_seen = mem_read_request;
    end

    // SDRAM stand-in, one strobe per word with random gaps
    initial begin : memory_model
        addr_t base;
        int    idx;
        int    gap;
        logic  live;
        mem_data_ready = 1'b0;
        mem_data_in    = '0;
        lcg_state      = 32'h2883;
        forever begin
            @(negedge Clk);
            if (!reset && mem_read_request) begin
                base = mem_read_address;
                idx  = 0;
                live = 1'b1;
                while (live && idx < BLOCK_WORDS) begin
                    gap = int'(next_random() >> 16) % 4;
                    while (live && gap > 0) begin
                        @(negedge Clk);
                        live = mem_read_request;
                        gap--;
                    end
                    if (live) begin
                        mem_data_ready = 1'b1;
                        mem_data_in    = memory_word(base + addr_t'(4 * idx));
                        @(negedge Clk);
                        mem_data_ready = 1'b0;
                        live           = mem_read_request;
                        idx++;
                    end
                end
            end
        end
    end

    initial begin : main
        int    fd;
        int    n;
        string line;
        string name;
        addr_t addr;
        word_t word;
        int    mode;
        int    hit_flag;
        Clk          = 1'b0;
        reset        = 1'b1;
        read_enable  = 1'b0;
        read_address = '0;
        mispredict   = 1'b0;
        repeat (8) @(negedge Clk);
        reset = 1'b0;

        fd = $fopen("icache_golden.txt", "r");
        if (fd == 0) begin
            $display("Could not open icache_golden.txt");
            aborted = 1'b1;
        end else begin
            while (!aborted && $fgets(line, fd) != 0) begin
                if (line.len() < 2 || line[0] == "#") begin
                    continue;
                end
                case (line[0])
                    "M": begin
                        n = $sscanf(line, "M %h %h", addr, word);
                        if (n == 2) begin
                            mem_image[addr] = word;
                        end
                    end
                    "T": begin
                        finish_test();
                        n            = $sscanf(line, "T %s", name);
                        test_name    = name;
                        test_open    = 1'b1;
                        test_errors  = 0;
                        test_fetches = 0;
                        n            = (n == 1) ? 2 : 0;
                    end
                    "F": begin
                        n = $sscanf(line, "F %h %d %h %d", addr, mode, word, hit_flag);
                        if (n == 4) begin
                            run_fetch(addr, mode, word, hit_flag != 0);
                            n = 2;
                        end
                    end
                    default: begin
                        n = 0;
                    end
                endcase
                // Every accepted line kind leaves two here
                if (n != 2) begin
                    $display("Golden file line not understood: %s", line);
                    aborted = 1'b1;
                end
            end
            $fclose(fd);
        end

        finish_test();
        check_value("assertion failures", dut0.asserts0.fail_count, 0);
        $display("%0d tests, %0d failed, %0d fetches, %0d errors", tests_run, tests_failed,
                 fetch_count, errors);
        if (errors == 0 && !aborted) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb_icache_asserts.sv */
`default_nettype none

module tb_icache_asserts #(
    parameter int BLOCK_WORDS = 4
) (
    input logic                    Clk,
    input logic                    reset,
    input logic                    read_enable,
    input icache_pkg::addr_t       read_address,
    input logic                    mispredict,
    input logic                    ready,
    input logic                    busy,
    input icache_pkg::addr_t       mem_read_address,
    input logic                    mem_read_request,
    input icache_pkg::ctrl_state_e state
);

    timeunit 1ns;
    timeprecision 1ps;

    import icache_pkg::*;

    localparam int OFF_W = $clog2(BLOCK_WORDS) + 2;

    int fail_count = 0;

    // A new strobe in the ready cycle may legally hit again
    ready_pulse: assert property (@(posedge Clk) disable iff (reset)
        (ready && !read_enable) |=> !ready)
        else begin
            $error("ready stayed high for more than one cycle");
            fail_count++;
        end

    reset_quiet: assert property (@(posedge Clk)
        reset |=> (!mem_read_request && !busy))
        else begin
            $error("memory request or busy high after reset");
            fail_count++;
        end

    // Request carries the block of the fetch strobed one cycle earlier
    request_aligned: assert property (@(posedge Clk) disable iff (reset)
        $rose(mem_read_request) |->
            (mem_read_address == ($past(read_address) & ~addr_t'(2 ** OFF_W - 1))))
        else begin
            $error("memory request address is not the aligned fetch address");
            fail_count++;
        end

    // Cancel during a refill drops the request and busy next cycle
    cancel_drops: assert property (@(posedge Clk) disable iff (reset)
        ((state == REFILL) && mispredict) |=> (!mem_read_request && !busy))
        else begin
            $error("refill not cancelled after mispredict");
            fail_count++;
        end

endmodule

bind icache_top tb_icache_asserts #(
    .BLOCK_WORDS(BLOCK_WORDS)
) asserts0 (
    .Clk             (Clk),
    .reset           (reset),
    .read_enable     (read_enable),
    .read_address    (read_address),
    .mispredict      (mispredict),
    .ready           (ready),
    .busy            (busy),
    .mem_read_address(mem_read_address),
    .mem_read_request(mem_read_request),
    .state           (ctrl0.state)
);

`default_nettype wire
